// ==== fe_pkg.sv ====
`default_nettype none

package fe_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_word_t;
  typedef logic [4:0]  reg_idx_t;
  // Slot 0 in the low word, slot 1 in the high word
  typedef logic [63:0] fetch_pair_t;
  typedef logic [1:0]  slot_cnt_t;

  typedef enum logic [2:0] {
    CLS_ADD,
    CLS_ADDI,
    CLS_STW,
    CLS_BEQ,
    CLS_BL,
    CLS_IDLE,
    CLS_ILLEGAL
  } inst_class_e;

  typedef enum logic [1:0] {R0_NONE, R0_RK, R0_RD} r0_src_e;
  typedef enum logic {R1_NONE, R1_RJ} r1_src_e;
  typedef enum logic [1:0] {W_NONE, W_RD, W_R1} w_src_e;

  // Major opcode fields
  localparam logic [16:0] OPC_ADD_W  = 17'h00020;
  localparam logic [9:0]  OPC_ADDI_W = 10'h00A;
  localparam logic [9:0]  OPC_ST_W   = 10'h0A6;
  localparam logic [5:0]  OPC_BEQ    = 6'h16;
  localparam logic [5:0]  OPC_BL     = 6'h15;
  localparam logic [16:0] OPC_IDLE   = 17'h00C91;

  localparam addr_t RESET_PC = 32'h1c000000;

endpackage

`default_nettype wire

// ==== fe_npc.sv ====
`default_nettype none

module fe_npc #(
  parameter fe_pkg::addr_t BOOT_PC = fe_pkg::RESET_PC
) (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          fetch_fire_i,
  input  wire logic          redirect_i,
  input  wire fe_pkg::addr_t redirect_pc_i,
  output fe_pkg::addr_t      pc_o
);

  fe_pkg::addr_t pc_q;
  fe_pkg::addr_t pc_seq;

  // Next aligned pair, a half-pair target still moves a full pair on
  assign pc_seq = {pc_q[31:3], 3'b000} + 32'd8;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= BOOT_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (fetch_fire_i) begin
      pc_q <= pc_seq;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== fe_fetch.sv ====
`default_nettype none

module fe_fetch #(
  parameter int QUEUE_DEPTH = 16
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire fe_pkg::addr_t                  pc_i,
  input  wire logic [$clog2(QUEUE_DEPTH):0]   free_slots_i,
  input  wire logic                           idle_lock_i,
  input  wire logic                           redirect_i,
  output logic                                fetch_fire_o,
  output logic                                imem_req_o,
  output fe_pkg::addr_t                       imem_addr_o,
  input  wire fe_pkg::fetch_pair_t            imem_rdata_i,
  output fe_pkg::slot_cnt_t                   wr_num_o,
  output fe_pkg::addr_t [1:0]                 wr_pc_o,
  output fe_pkg::inst_word_t [1:0]            wr_inst_o
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

  logic          inflight_q;
  fe_pkg::addr_t req_pc_q;
  logic          fire;

  // Room for the pair in flight plus the pair being written now
  assign fire = rst_n && !idle_lock_i && !redirect_i && (free_slots_i >= CNT_W'(4));

  assign fetch_fire_o = fire;
  assign imem_req_o   = fire;
  assign imem_addr_o  = {pc_i[31:3], 3'b000};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      req_pc_q <= pc_i;
    end
  end

  // Odd target keeps only the high word in slot 0
  always_comb begin
    wr_pc_o[0]   = {req_pc_q[31:3], req_pc_q[2], 2'b00};
    wr_pc_o[1]   = {req_pc_q[31:3], 3'b100};
    wr_inst_o[0] = req_pc_q[2] ? imem_rdata_i[63:32] : imem_rdata_i[31:0];
    wr_inst_o[1] = imem_rdata_i[63:32];
    if (!inflight_q || redirect_i) begin
      wr_num_o = 2'd0;
    end else if (req_pc_q[2]) begin
      wr_num_o = 2'd1;
    end else begin
      wr_num_o = 2'd2;
    end
  end

endmodule

`default_nettype wire

// ==== fe_inst_queue.sv ====
`default_nettype none

module fe_inst_queue #(
  parameter int QUEUE_DEPTH = 16
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         flush_i,
  input  wire fe_pkg::slot_cnt_t            wr_num_i,
  input  wire fe_pkg::addr_t [1:0]          wr_pc_i,
  input  wire fe_pkg::inst_word_t [1:0]     wr_inst_i,
  input  wire fe_pkg::slot_cnt_t            rd_num_i,
  output logic [1:0]                        rd_valid_o,
  output fe_pkg::addr_t [1:0]               rd_pc_o,
  output fe_pkg::inst_word_t [1:0]          rd_inst_o,
  output logic [$clog2(QUEUE_DEPTH):0]      free_slots_o
);

  // Depth is a power of two so the pointers wrap on their own
  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  fe_pkg::addr_t      pc_mem   [QUEUE_DEPTH];
  fe_pkg::inst_word_t inst_mem [QUEUE_DEPTH];

  ptr_t head_q;
  ptr_t tail_q;
  cnt_t count_q;
  ptr_t head_nxt;
  ptr_t tail_nxt;

  assign head_nxt = head_q + ptr_t'(1);
  assign tail_nxt = tail_q + ptr_t'(1);

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + ptr_t'(rd_num_i);
      tail_q  <= tail_q + ptr_t'(wr_num_i);
      count_q <= count_q + cnt_t'(wr_num_i) - cnt_t'(rd_num_i);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_num_i != 2'd0) begin
      pc_mem[tail_q]   <= wr_pc_i[0];
      inst_mem[tail_q] <= wr_inst_i[0];
    end
    if (wr_num_i == 2'd2) begin
      pc_mem[tail_nxt]   <= wr_pc_i[1];
      inst_mem[tail_nxt] <= wr_inst_i[1];
    end
  end

  // Head pair, slot 0 is the oldest
  assign rd_pc_o[0]   = pc_mem[head_q];
  assign rd_pc_o[1]   = pc_mem[head_nxt];
  assign rd_inst_o[0] = inst_mem[head_q];
  assign rd_inst_o[1] = inst_mem[head_nxt];

  assign rd_valid_o[0] = count_q != cnt_t'(0);
  assign rd_valid_o[1] = count_q >= cnt_t'(2);

  assign free_slots_o = cnt_t'(QUEUE_DEPTH) - count_q;

endmodule

`default_nettype wire

// ==== fe_decoder.sv ====
`default_nettype none

module fe_decoder (
  input  wire fe_pkg::inst_word_t inst_i,
  output fe_pkg::inst_class_e     class_o,
  output fe_pkg::reg_idx_t        r0_o,
  output fe_pkg::reg_idx_t        r1_o,
  output fe_pkg::reg_idx_t        w_o
);

  fe_pkg::inst_class_e cls;
  fe_pkg::r0_src_e     r0_sel;
  fe_pkg::r1_src_e     r1_sel;
  fe_pkg::w_src_e      w_sel;

  always_comb begin
    if (inst_i[31:15] == fe_pkg::OPC_ADD_W) begin
      cls = fe_pkg::CLS_ADD;
    end else if (inst_i[31:15] == fe_pkg::OPC_IDLE) begin
      cls = fe_pkg::CLS_IDLE;
    end else if (inst_i[31:22] == fe_pkg::OPC_ADDI_W) begin
      cls = fe_pkg::CLS_ADDI;
    end else if (inst_i[31:22] == fe_pkg::OPC_ST_W) begin
      cls = fe_pkg::CLS_STW;
    end else if (inst_i[31:26] == fe_pkg::OPC_BEQ) begin
      cls = fe_pkg::CLS_BEQ;
    end else if (inst_i[31:26] == fe_pkg::OPC_BL) begin
      cls = fe_pkg::CLS_BL;
    end else begin
      cls = fe_pkg::CLS_ILLEGAL;
    end
  end

  // Register source selection per class
  always_comb begin
    r0_sel = fe_pkg::R0_NONE;
    r1_sel = fe_pkg::R1_NONE;
    w_sel  = fe_pkg::W_NONE;
    case (cls)
      fe_pkg::CLS_ADD: begin
        r0_sel = fe_pkg::R0_RK;
        r1_sel = fe_pkg::R1_RJ;
        w_sel  = fe_pkg::W_RD;
      end
      fe_pkg::CLS_ADDI: begin
        r1_sel = fe_pkg::R1_RJ;
        w_sel  = fe_pkg::W_RD;
      end
      // Stores and branches read rd as data
      fe_pkg::CLS_STW, fe_pkg::CLS_BEQ: begin
        r0_sel = fe_pkg::R0_RD;
        r1_sel = fe_pkg::R1_RJ;
      end
      fe_pkg::CLS_BL: begin
        w_sel = fe_pkg::W_R1;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    case (r0_sel)
      fe_pkg::R0_RK: r0_o = inst_i[14:10];
      fe_pkg::R0_RD: r0_o = inst_i[4:0];
      default:       r0_o = '0;
    endcase
    case (r1_sel)
      fe_pkg::R1_RJ: r1_o = inst_i[9:5];
      default:       r1_o = '0;
    endcase
    case (w_sel)
      fe_pkg::W_RD: w_o = inst_i[4:0];
      fe_pkg::W_R1: w_o = fe_pkg::reg_idx_t'(1);
      default:      w_o = '0;
    endcase
  end

  assign class_o = cls;

endmodule

`default_nettype wire

// ==== frontend.sv ====
`default_nettype none

module frontend #(
  parameter int            QUEUE_DEPTH = 16,
  parameter fe_pkg::addr_t BOOT_PC     = fe_pkg::RESET_PC
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  output logic                            imem_req_o,
  output fe_pkg::addr_t                   imem_addr_o,
  input  wire fe_pkg::fetch_pair_t        imem_rdata_i,
  input  wire logic                       redirect_i,
  input  wire fe_pkg::addr_t              redirect_pc_i,
  input  wire fe_pkg::slot_cnt_t          accept_num_i,
  output logic [1:0]                      out_valid_o,
  output fe_pkg::addr_t [1:0]             out_pc_o,
  output fe_pkg::inst_word_t [1:0]        out_inst_o,
  output fe_pkg::inst_class_e [1:0]       out_class_o,
  output fe_pkg::reg_idx_t [1:0]          out_r0_o,
  output fe_pkg::reg_idx_t [1:0]          out_r1_o,
  output fe_pkg::reg_idx_t [1:0]          out_w_o
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

  fe_pkg::addr_t            pc;
  logic                     fetch_fire;
  logic [CNT_W-1:0]         free_slots;
  fe_pkg::slot_cnt_t        wr_num;
  fe_pkg::addr_t [1:0]      wr_pc;
  fe_pkg::inst_word_t [1:0] wr_inst;
  logic                     idle_lock_q;
  logic                     idle_pop;

  // Only popped slots count, an IDLE still waiting in the queue does not lock
  assign idle_pop = ((accept_num_i != 2'd0) && (out_class_o[0] == fe_pkg::CLS_IDLE)) ||
                    ((accept_num_i == 2'd2) && (out_class_o[1] == fe_pkg::CLS_IDLE));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_lock_q <= 1'b0;
    end else if (redirect_i) begin
      idle_lock_q <= 1'b0;
    end else if (idle_pop) begin
      idle_lock_q <= 1'b1;
    end
  end

  fe_npc #(.BOOT_PC(BOOT_PC)) u_npc (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_fire_i  (fetch_fire),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc)
  );

  fe_fetch #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc),
    .free_slots_i (free_slots),
    .idle_lock_i  (idle_lock_q),
    .redirect_i   (redirect_i),
    .fetch_fire_o (fetch_fire),
    .imem_req_o   (imem_req_o),
    .imem_addr_o  (imem_addr_o),
    .imem_rdata_i (imem_rdata_i),
    .wr_num_o     (wr_num),
    .wr_pc_o      (wr_pc),
    .wr_inst_o    (wr_inst)
  );

  fe_inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i),
    .wr_num_i     (wr_num),
    .wr_pc_i      (wr_pc),
    .wr_inst_i    (wr_inst),
    .rd_num_i     (accept_num_i),
    .rd_valid_o   (out_valid_o),
    .rd_pc_o      (out_pc_o),
    .rd_inst_o    (out_inst_o),
    .free_slots_o (free_slots)
  );

  for (genvar g = 0; g < 2; g++) begin : g_dec
    fe_decoder u_dec (
      .inst_i  (out_inst_o[g]),
      .class_o (out_class_o[g]),
      .r0_o    (out_r0_o[g]),
      .r1_o    (out_r1_o[g]),
      .w_o     (out_w_o[g])
    );
  end

endmodule

`default_nettype wire

// ==== frontend_checker.sv ====
`default_nettype none

module frontend_checker (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      redirect_i,
  input  wire fe_pkg::slot_cnt_t         accept_num_i,
  input  wire logic [1:0]                out_valid_o,
  input  wire fe_pkg::addr_t [1:0]       out_pc_o,
  input  wire fe_pkg::inst_word_t [1:0]  out_inst_o,
  input  wire fe_pkg::inst_class_e [1:0] out_class_o,
  input  wire fe_pkg::reg_idx_t [1:0]    out_r0_o,
  input  wire fe_pkg::reg_idx_t [1:0]    out_r1_o,
  input  wire fe_pkg::reg_idx_t [1:0]    out_w_o,
  output logic                           locked_o,
  output logic                           done_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] exp_rec [$][6];
  int idx = 0;
  int errors = 0;

  task automatic push_record(input logic [31:0] pc, inst, cls, r0, r1, w);
    exp_rec.push_back('{pc, inst, cls, r0, r1, w});
  endtask

  task automatic note_error(input string msg);
    $display("ERROR: %s", msg);
    errors++;
  endtask

  task automatic compare(input string name, input logic [31:0] exp_v, act_v);
    if (exp_v !== act_v) begin
      $display("FAILED %s expected %h actual %h", name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic print_summary();
    $display("checked %0d of %0d records, %0d errors", idx, exp_rec.size(), errors);
  endtask

  always @(posedge clk) begin
    logic lock;
    lock = locked_o;
    if (!rst_n || redirect_i) begin
      lock = 1'b0;
    end else begin
      for (int s = 0; s < 2; s++) begin
        if (s < int'(accept_num_i)) begin
          if (!out_valid_o[s]) begin
            note_error($sformatf("slot %0d accepted while not valid", s));
          end else if (!lock && idx < exp_rec.size()) begin
            compare($sformatf("record %0d pc", idx), exp_rec[idx][0], out_pc_o[s]);
            compare($sformatf("record %0d inst", idx), exp_rec[idx][1], out_inst_o[s]);
            compare($sformatf("record %0d class", idx), exp_rec[idx][2], 32'(out_class_o[s]));
            compare($sformatf("record %0d r0", idx), exp_rec[idx][3], 32'(out_r0_o[s]));
            compare($sformatf("record %0d r1", idx), exp_rec[idx][4], 32'(out_r1_o[s]));
            compare($sformatf("record %0d w", idx), exp_rec[idx][5], 32'(out_w_o[s]));
            // Younger items stay unchecked until the redirect
            if (out_class_o[s] == fe_pkg::CLS_IDLE) begin
              lock = 1'b1;
            end
            idx++;
          end
        end
      end
    end
    locked_o <= lock;
    done_o   <= (exp_rec.size() > 0) && (idx >= exp_rec.size());
  end

endmodule

`default_nettype wire

// ==== frontend_sva.sv ====
`default_nettype none

module frontend_sva (
  input wire logic                      clk,
  input wire logic                      rst_n,
  input wire logic                      redirect_i,
  input wire fe_pkg::slot_cnt_t         accept_num_i,
  input wire logic [1:0]                out_valid_o,
  input wire fe_pkg::addr_t [1:0]       out_pc_o,
  input wire fe_pkg::inst_class_e [1:0] out_class_o,
  input wire logic                      imem_req_o,
  input wire fe_pkg::addr_t             imem_addr_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic idle_accepted;

  // An IDLE leaving the queue this cycle
  assign idle_accepted =
    ((accept_num_i != 2'd0) && (out_class_o[0] == fe_pkg::CLS_IDLE)) ||
    ((accept_num_i == 2'd2) && (out_class_o[1] == fe_pkg::CLS_IDLE));

  a_valid_contig: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o[1] |-> out_valid_o[0] && (out_pc_o[1] == out_pc_o[0] + 32'd4))
    else $error("slot 1 valid without the preceding instruction in slot 0");

  a_no_req_locked: assert property (@(posedge clk) disable iff (!rst_n)
    idle_accepted && !redirect_i |=> !imem_req_o)
    else $error("memory request after an accepted IDLE");

  a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_o && $past(imem_req_o) |->
      (imem_addr_o == {$past(imem_addr_o[31:3]) + 29'd1, 3'b000}))
    else $error("fetch address is not the next aligned pair");

endmodule

bind frontend frontend_sva u_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .redirect_i   (redirect_i),
  .accept_num_i (accept_num_i),
  .out_valid_o  (out_valid_o),
  .out_pc_o     (out_pc_o),
  .out_class_o  (out_class_o),
  .imem_req_o   (imem_req_o),
  .imem_addr_o  (imem_addr_o)
);

`default_nettype wire

// ==== tb_frontend.sv ====
`default_nettype none

module tb_frontend;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic rst_n;
  logic imem_req_o;
  fe_pkg::addr_t imem_addr_o;
  fe_pkg::fetch_pair_t imem_rdata_i;
  logic redirect_i;
  fe_pkg::addr_t redirect_pc_i;
  fe_pkg::slot_cnt_t accept_num_i;
  logic [1:0] out_valid_o;
  fe_pkg::addr_t [1:0] out_pc_o;
  fe_pkg::inst_word_t [1:0] out_inst_o;
  fe_pkg::inst_class_e [1:0] out_class_o;
  fe_pkg::reg_idx_t [1:0] out_r0_o;
  fe_pkg::reg_idx_t [1:0] out_r1_o;
  fe_pkg::reg_idx_t [1:0] out_w_o;
  logic chk_locked;
  logic chk_done;

  logic [31:0] mem [logic [31:0]];
  logic [31:0] targets [$];
  int seed = 82368;
  int cycles = 0;
  int limit = 0;

  frontend #(.QUEUE_DEPTH(16), .BOOT_PC(32'h1c000000)) UUT (
    .clk(clk), .rst_n(rst_n), .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o),
    .imem_rdata_i(imem_rdata_i), .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
    .accept_num_i(accept_num_i), .out_valid_o(out_valid_o), .out_pc_o(out_pc_o),
    .out_inst_o(out_inst_o), .out_class_o(out_class_o), .out_r0_o(out_r0_o),
    .out_r1_o(out_r1_o), .out_w_o(out_w_o)
  );

  frontend_checker chk (
    .clk(clk), .rst_n(rst_n), .redirect_i(redirect_i), .accept_num_i(accept_num_i),
    .out_valid_o(out_valid_o), .out_pc_o(out_pc_o), .out_inst_o(out_inst_o),
    .out_class_o(out_class_o), .out_r0_o(out_r0_o), .out_r1_o(out_r1_o),
    .out_w_o(out_w_o), .locked_o(chk_locked), .done_o(chk_done)
  );

  always #20 clk = ~clk;

  // Unloaded words get a pattern built from the full address
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return addr ^ 32'h5a5a_a5a5;
  endfunction

  always @(posedge clk) begin
    if (imem_req_o) begin
      imem_rdata_i <= {word_at(imem_addr_o + 32'd4), word_at(imem_addr_o)};
    end
  end

  // Items left after this edge are at least the old count minus the old accept
  always @(posedge clk) begin
    int avail;
    int pick;
    avail = int'(out_valid_o[0]) + int'(out_valid_o[1]) - int'(accept_num_i);
    pick = int'($unsigned($random(seed)) % 4);
    if (pick == 3 || (cycles % 64) < 20) begin
      pick = 0;
    end
    if (!rst_n || redirect_i || avail < 0) begin
      avail = 0;
    end
    accept_num_i <= fe_pkg::slot_cnt_t'((pick < avail) ? pick : avail);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the expected stream did not complete in %0d cycles", limit);
      chk.print_summary();
      $display("sim failed");
      $finish;
    end
  end

  task automatic load_trace();
    int fd;
    int n_rec;
    logic [7:0] tag;
    logic [8*128-1:0] line;
    logic [31:0] f [6];
    fd = $fopen("frontend_trace.txt", "r");
    n_rec = 0;
    if (fd == 0) begin
      chk.note_error("cannot open frontend_trace.txt");
      limit = 200;
      return;
    end
    while ($fscanf(fd, " %c", tag) == 1) begin
      if (tag == "M") begin
        void'($fscanf(fd, "%h %h", f[0], f[1]));
        mem[f[0]] = f[1];
      end else if (tag == "E") begin
        void'($fscanf(fd, "%h %h %d %d %d %d", f[0], f[1], f[2], f[3], f[4], f[5]));
        chk.push_record(f[0], f[1], f[2], f[3], f[4], f[5]);
        n_rec++;
      end else if (tag == "R") begin
        void'($fscanf(fd, "%h", f[0]));
        targets.push_back(f[0]);
      end else begin
        void'($fgets(line, fd));
      end
    end
    $fclose(fd);
    limit = 40 * n_rec + 200;
  endtask

  // Watch the request line after an accepted IDLE and wake the core with a redirect
  task automatic idle_then_redirect();
    logic req_seen;
    req_seen = 1'b0;
    for (int i = 0; i < 30; i++) begin
      @(posedge clk);
      if (i >= 20 && imem_req_o) begin
        req_seen = 1'b1;
      end
    end
    if (req_seen) begin
      chk.note_error("fetch requests continued while the idle lock was set");
    end
    redirect_i    <= 1'b1;
    redirect_pc_i <= targets.pop_front();
    @(posedge clk);
    redirect_i <= 1'b0;
    @(posedge clk);
  endtask

  initial begin
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    accept_num_i  = '0;
    imem_rdata_i  = '0;
    load_trace();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    while (!chk_done) begin
      @(posedge clk);
      if (chk_locked && targets.size() > 0) begin
        idle_then_redirect();
      end
    end
    chk.print_summary();
    if (chk.errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== frontend_trace.txt ====
# M <byte addr> <word>      memory image
# E <pc> <inst> <class> <r0> <r1> <w>      expected decode record
# R <target>      redirect issued after the idle lock is seen
M 1c000000 00100c41
M 1c000004 02801485
M 1c000008 29802067
M 1c00000c 580010c9
M 1c000010 54000400
M 1c000014 ffffffff
M 1c000018 0010296c
M 1c00001c 06488000
M 1c000100 00100c41
M 1c000104 02801485
M 1c000108 54000400
M 1c00010c 0010296c
M 1c000110 06488000
E 1c000000 00100c41 0 3 2 1
E 1c000004 02801485 1 0 4 5
E 1c000008 29802067 2 7 3 0
E 1c00000c 580010c9 3 9 6 0
E 1c000010 54000400 4 0 0 1
E 1c000014 ffffffff 6 0 0 0
E 1c000018 0010296c 0 10 11 12
E 1c00001c 06488000 5 0 0 0
R 1c000104
E 1c000104 02801485 1 0 4 5
E 1c000108 54000400 4 0 0 1
E 1c00010c 0010296c 0 10 11 12
E 1c000110 06488000 5 0 0 0

// ==== frontend.f ====
fe_pkg.sv
fe_npc.sv
fe_fetch.sv
fe_inst_queue.sv
fe_decoder.sv
frontend.sv
frontend_checker.sv
frontend_sva.sv
tb_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_frontend -f frontend.f -o sim_frontend
out=$(./obj_dir/sim_frontend)
echo "$out"
if echo "$out" | grep -qx "sim passed"; then
  exit 0
else
  exit 1
fi
